// ==== flist.f ====
rtl/cpuPkg.sv
rtl/memBusIf.sv
rtl/decoder.sv
rtl/alu.sv
rtl/regFile.sv
rtl/pcUnit.sv
rtl/busSequencer.sv
rtl/wishboneManager.sv
rtl/cpuTop.sv
test/cpuTop_sva.sv
test/cpuTb.sv

// ==== rtl/alu.sv ====
`timescale 1ns/100ps

module alu import cpuPkg::*; (
	input logic [XLEN-1:0] opA_i,
	input logic [XLEN-1:0] opB_i,
	input aluOpT op_i,
	output logic [XLEN-1:0] result_o,
	output logic zero_o
);
	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = opB_i[4:0];
	assign lessSigned = $signed(opA_i) < $signed(opB_i);
	assign lessUnsigned = opA_i < opB_i;

	always_comb begin
		case (op_i)
			ALU_ADD: result_o = opA_i + opB_i;
			ALU_SUB: result_o = opA_i - opB_i;
			ALU_SLL: result_o = opA_i << shamt;
			ALU_SRL: result_o = opA_i >> shamt;
			ALU_SRA: result_o = $signed(opA_i) >>> shamt;
			ALU_XOR: result_o = opA_i ^ opB_i;
			ALU_OR: result_o = opA_i | opB_i;
			ALU_AND: result_o = opA_i & opB_i;
			ALU_SLT: result_o = {{(XLEN-1){1'b0}}, lessSigned};
			ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lessUnsigned};
			default: result_o = '0;
		endcase
	end

	// branches read this.
	assign zero_o = (result_o == '0);
endmodule

// ==== rtl/busSequencer.sv ====
`timescale 1ns/100ps

module busSequencer import cpuPkg::*; (
	input logic CLK,
	input logic nRST,
	input logic en_i,
	input logic [XLEN-1:0] pc_i,
	input logic [XLEN-1:0] aluResult_i,
	input logic [XLEN-1:0] storeData_i,
	input logic memRead_i,
	input logic memWrite_i,
	memBusIf.seq bus,
	output logic [XLEN-1:0] instr_o,
	output logic [XLEN-1:0] loadData_o,
	output logic retire_o
);
	typedef enum logic [2:0] {FETCH_REQ, FETCH_WAIT, EXEC, DATA_REQ, DATA_WAIT} stateT;

	stateT state, nextState;
	logic [XLEN-1:0] dataAddr;

	assign dataAddr = aluResult_i + DATA_BASE;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= FETCH_REQ;
		end else begin
			state <= nextState;
		end
	end

	// instruction register.
	always_ff @(posedge CLK) begin
		if ((state == FETCH_WAIT) && !bus.busy) begin
			instr_o <= bus.rdata;
		end
	end

	// the manager keeps the loaded word until the next read.
	assign loadData_o = bus.rdata;

	always_comb begin
		nextState = state;
		bus.read = 1'b0;
		bus.write = 1'b0;
		bus.addr = pc_i;
		bus.wdata = storeData_i;
		retire_o = 1'b0;
		case (state)
			FETCH_REQ: begin
				if (en_i && !bus.busy) begin
					bus.read = 1'b1;
					nextState = FETCH_WAIT;
				end
			end
			FETCH_WAIT: begin
				if (!bus.busy) nextState = EXEC;
			end
			EXEC: begin
				if (!en_i) begin
					nextState = FETCH_REQ; // dropped, nothing retires.
				end else if (memRead_i || memWrite_i) begin
					nextState = DATA_REQ;
				end else begin
					retire_o = 1'b1;
					nextState = FETCH_REQ;
				end
			end
			DATA_REQ: begin
				bus.addr = dataAddr;
				if (en_i) begin
					bus.read = memRead_i;
					bus.write = memWrite_i;
					nextState = DATA_WAIT;
				end else begin
					nextState = FETCH_REQ;
				end
			end
			DATA_WAIT: begin
				bus.addr = dataAddr;
				if (!bus.busy) begin
					retire_o = en_i;
					nextState = FETCH_REQ;
				end
			end
			default: nextState = FETCH_REQ;
		endcase
	end
endmodule

// ==== rtl/cpuPkg.sv ====
package cpuPkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] RESET_PC = 32'h3300_0000;
	localparam logic [XLEN-1:0] DATA_BASE = 32'h3300_0000;

	// major opcodes.
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;

	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_ADD = 3'b000; // also sub.
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101; // srl and sra.
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_WORD = 3'b010; // lw and sw.

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_XOR, ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU
	} aluOpT;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK, WB_UPIMM} wbSelT;

	typedef enum logic [1:0] {PC_SEQ, PC_JAL, PC_JALR, PC_BRANCH} pcSelT;

	typedef struct packed {
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0] imm;
		aluOpT aluOp;
		logic aluSrcImm;
		logic aluSrcPc; // auipc.
		logic regWrite;
		logic memRead;
		logic memWrite;
		wbSelT wbSel;
		pcSelT pcSel;
		logic brInvert; // branch taken on a nonzero compare.
		logic illegal;
	} ctrlT;

endpackage

// ==== rtl/cpuTop.sv ====
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; (
	input logic CLK,
	input logic nRST,
	input logic en_i,
	input logic [XLEN-1:0] wbDat_i,
	input logic wbAck_i,
	output logic [XLEN-1:0] wbAdr_o,
	output logic [XLEN-1:0] wbDat_o,
	output logic [3:0] wbSel_o,
	output logic wbWe_o,
	output logic wbStb_o,
	output logic wbCyc_o
);
	ctrlT ctrl;
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] aluResult;
	logic [XLEN-1:0] loadData;
	logic [XLEN-1:0] wbData;
	logic aluZero;
	logic retire;

	memBusIf bus ();

	assign opA = ctrl.aluSrcPc ? pc : rs1Data;
	assign opB = ctrl.aluSrcImm ? ctrl.imm : rs2Data;

	always_comb begin
		case (ctrl.wbSel)
			WB_MEM: wbData = loadData;
			WB_LINK: wbData = pc + 32'd4;
			WB_UPIMM: wbData = ctrl.imm; // lui.
			default: wbData = aluResult;
		endcase
	end

	decoder u_decoder (
		.instr_i(instr),
		.ctrl_o(ctrl)
	);

	regFile u_regFile (
		.CLK(CLK),
		.nRST(nRST),
		.we_i(retire && ctrl.regWrite),
		.rs1_i(ctrl.rs1),
		.rs2_i(ctrl.rs2),
		.rd_i(ctrl.rd),
		.wdata_i(wbData),
		.rdata1_o(rs1Data),
		.rdata2_o(rs2Data)
	);

	alu u_alu (
		.opA_i(opA),
		.opB_i(opB),
		.op_i(ctrl.aluOp),
		.result_o(aluResult),
		.zero_o(aluZero)
	);

	pcUnit u_pcUnit (
		.CLK(CLK),
		.nRST(nRST),
		.en_i(en_i),
		.retire_i(retire),
		.pcSel_i(ctrl.pcSel),
		.brInvert_i(ctrl.brInvert),
		.aluZero_i(aluZero),
		.imm_i(ctrl.imm),
		.rs1Data_i(rs1Data),
		.pc_o(pc)
	);

	busSequencer u_busSequencer (
		.CLK(CLK),
		.nRST(nRST),
		.en_i(en_i),
		.pc_i(pc),
		.aluResult_i(aluResult),
		.storeData_i(rs2Data),
		.memRead_i(ctrl.memRead),
		.memWrite_i(ctrl.memWrite),
		.bus(bus.seq),
		.instr_o(instr),
		.loadData_o(loadData),
		.retire_o(retire)
	);

	wishboneManager u_wishboneManager (
		.CLK(CLK),
		.nRST(nRST),
		.bus(bus.mgr),
		.wbDat_i(wbDat_i),
		.wbAck_i(wbAck_i),
		.wbAdr_o(wbAdr_o),
		.wbDat_o(wbDat_o),
		.wbSel_o(wbSel_o),
		.wbWe_o(wbWe_o),
		.wbStb_o(wbStb_o),
		.wbCyc_o(wbCyc_o)
	);
endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/100ps

module decoder import cpuPkg::*; (
	input logic [XLEN-1:0] instr_i,
	output ctrlT ctrl_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [XLEN-1:0] immI, immS, immB, immU, immJ;

	function automatic aluOpT aluFromF3(input logic [2:0] f3, input logic alt);
		case (f3)
			F3_ADD: return alt ? ALU_SUB : ALU_ADD;
			F3_SLL: return ALU_SLL;
			F3_SLT: return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR: return ALU_XOR;
			F3_SR: return alt ? ALU_SRA : ALU_SRL;
			F3_OR: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];

	assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
	assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign immU = {instr_i[31:12], 12'b0};
	assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21],
		1'b0};

	always_comb begin
		ctrl_o = '0;
		ctrl_o.rs1 = instr_i[19:15];
		ctrl_o.rs2 = instr_i[24:20];
		ctrl_o.rd = instr_i[11:7];
		ctrl_o.aluOp = ALU_ADD;
		ctrl_o.wbSel = WB_ALU;
		ctrl_o.pcSel = PC_SEQ;
		case (opcode)
			OPC_LUI: begin
				ctrl_o.imm = immU;
				ctrl_o.regWrite = 1'b1;
				ctrl_o.wbSel = WB_UPIMM;
			end
			OPC_AUIPC: begin
				ctrl_o.imm = immU;
				ctrl_o.aluSrcPc = 1'b1;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.regWrite = 1'b1;
			end
			OPC_JAL: begin
				ctrl_o.imm = immJ;
				ctrl_o.regWrite = 1'b1;
				ctrl_o.wbSel = WB_LINK;
				ctrl_o.pcSel = PC_JAL;
			end
			OPC_JALR: begin
				ctrl_o.imm = immI;
				ctrl_o.regWrite = 1'b1;
				ctrl_o.wbSel = WB_LINK;
				ctrl_o.pcSel = PC_JALR;
			end
			OPC_BRANCH: begin
				ctrl_o.imm = immB;
				ctrl_o.pcSel = PC_BRANCH;
				case (funct3)
					F3_BEQ: ctrl_o.aluOp = ALU_SUB;
					F3_BNE: begin
						ctrl_o.aluOp = ALU_SUB;
						ctrl_o.brInvert = 1'b1;
					end
					F3_BLT: begin
						ctrl_o.aluOp = ALU_SLT;
						ctrl_o.brInvert = 1'b1;
					end
					F3_BGE: ctrl_o.aluOp = ALU_SLT;
					F3_BLTU: begin
						ctrl_o.aluOp = ALU_SLTU;
						ctrl_o.brInvert = 1'b1;
					end
					F3_BGEU: ctrl_o.aluOp = ALU_SLTU;
					default: begin
						ctrl_o.illegal = 1'b1;
						ctrl_o.pcSel = PC_SEQ;
					end
				endcase
			end
			OPC_LOAD: begin
				ctrl_o.imm = immI;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.memRead = (funct3 == F3_WORD);
				ctrl_o.regWrite = (funct3 == F3_WORD);
				ctrl_o.wbSel = WB_MEM;
				ctrl_o.illegal = (funct3 != F3_WORD);
			end
			OPC_STORE: begin
				ctrl_o.imm = immS;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.memWrite = (funct3 == F3_WORD);
				ctrl_o.illegal = (funct3 != F3_WORD);
			end
			OPC_OPIMM: begin
				ctrl_o.imm = immI;
				ctrl_o.aluSrcImm = 1'b1;
				ctrl_o.regWrite = 1'b1;
				ctrl_o.aluOp = aluFromF3(funct3, instr_i[30] && (funct3 == F3_SR)); // addi has no sub.
			end
			OPC_OP: begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.aluOp = aluFromF3(funct3, instr_i[30]);
			end
			default: ctrl_o.illegal = 1'b1; // runs as a nop.
		endcase
	end
endmodule

// ==== rtl/memBusIf.sv ====
`timescale 1ns/100ps

interface memBusIf import cpuPkg::*; ();
	logic read;
	logic write;
	logic [XLEN-1:0] addr;
	logic [XLEN-1:0] wdata;
	logic [XLEN-1:0] rdata;
	logic busy;

	modport seq (
		output read, write, addr, wdata,
		input rdata, busy
	);

	// manager side.
	modport mgr (
		input read, write, addr, wdata,
		output rdata, busy
	);
endinterface

// ==== rtl/pcUnit.sv ====
`timescale 1ns/100ps

module pcUnit import cpuPkg::*; (
	input logic CLK,
	input logic nRST,
	input logic en_i,
	input logic retire_i,
	input pcSelT pcSel_i,
	input logic brInvert_i,
	input logic aluZero_i,
	input logic [XLEN-1:0] imm_i,
	input logic [XLEN-1:0] rs1Data_i,
	output logic [XLEN-1:0] pc_o
);
	logic [XLEN-1:0] pcPlus4;
	logic [XLEN-1:0] pcTarget;
	logic [XLEN-1:0] jalrTarget;
	logic taken;
	logic [XLEN-1:0] nextPc;

	assign pcPlus4 = pc_o + 32'd4;
	assign pcTarget = pc_o + imm_i;
	assign jalrTarget = (rs1Data_i + imm_i) & ~32'd1;
	assign taken = aluZero_i ^ brInvert_i;

	always_comb begin
		case (pcSel_i)
			PC_JAL: nextPc = pcTarget;
			PC_JALR: nextPc = jalrTarget;
			PC_BRANCH: nextPc = taken ? pcTarget : pcPlus4;
			default: nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			pc_o <= RESET_PC;
		end else if (!en_i) begin
			pc_o <= RESET_PC; // parked while disabled.
		end else if (retire_i) begin
			pc_o <= nextPc;
		end
	end
endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
	input logic CLK,
	input logic nRST,
	input logic we_i,
	input logic [REG_ADDR_W-1:0] rs1_i,
	input logic [REG_ADDR_W-1:0] rs2_i,
	input logic [REG_ADDR_W-1:0] rd_i,
	input logic [XLEN-1:0] wdata_i,
	output logic [XLEN-1:0] rdata1_o,
	output logic [XLEN-1:0] rdata2_o
);
	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (rd_i != '0)) begin // x0 stays zero.
			regs[rd_i] <= wdata_i;
		end
	end

	assign rdata1_o = regs[rs1_i];
	assign rdata2_o = regs[rs2_i];
endmodule

// ==== rtl/wishboneManager.sv ====
`timescale 1ns/100ps

module wishboneManager import cpuPkg::*; (
	input logic CLK,
	input logic nRST,
	memBusIf.mgr bus,
	input logic [XLEN-1:0] wbDat_i,
	input logic wbAck_i,
	output logic [XLEN-1:0] wbAdr_o,
	output logic [XLEN-1:0] wbDat_o,
	output logic [3:0] wbSel_o,
	output logic wbWe_o,
	output logic wbStb_o,
	output logic wbCyc_o
);
	typedef enum logic [1:0] {IDLE, READ, WRITE} stateT;

	stateT state;
	logic start;

	assign start = (state == IDLE) && (bus.read || bus.write);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			wbStb_o <= 1'b0;
			wbCyc_o <= 1'b0;
			wbWe_o <= 1'b0;
			wbSel_o <= 4'h0;
			bus.busy <= 1'b0;
		end else if (start) begin
			state <= bus.write ? WRITE : READ; // write wins.
			wbStb_o <= 1'b1;
			wbCyc_o <= 1'b1;
			wbWe_o <= bus.write;
			wbSel_o <= 4'hf; // word transfers only.
			bus.busy <= 1'b1;
		end else if ((state != IDLE) && wbAck_i) begin
			state <= IDLE;
			wbStb_o <= 1'b0;
			wbCyc_o <= 1'b0;
			wbWe_o <= 1'b0;
			wbSel_o <= 4'h0;
			bus.busy <= 1'b0;
		end
	end

	// address, store data and read data.
	always_ff @(posedge CLK) begin
		if (start) begin
			wbAdr_o <= bus.addr;
			wbDat_o <= bus.wdata;
		end
		if ((state == READ) && wbAck_i) begin
			bus.rdata <= wbDat_i;
		end
	end
endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cpuTop testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f flist.f -o cpuTb \
	> build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/cpuTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== test/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();
	localparam int NROWS = 32;
	localparam int PLEN = 8;
	localparam int MEM_WORDS = 128;
	localparam int TIMEOUT = PLEN * 16 * NROWS;
	localparam logic [31:0] NOP = 32'h0000_0013; // addi x0, x0, 0.

	logic CLK;
	logic nRST;
	logic en;
	logic [31:0] wbDatIn;
	logic wbAck;
	logic [31:0] wbAdr;
	logic [31:0] wbDatOut;
	logic [3:0] wbSel;
	logic wbWe;
	logic wbStb;
	logic wbCyc;

	string names [NROWS];
	logic [31:0] progs [NROWS][PLEN];
	logic [31:0] preload [NROWS];
	logic [31:0] expAdr [NROWS];
	logic [31:0] expDat [NROWS];
	int rowCount = 0;
	int curRow;
	int cycles = 0;

	logic [31:0] mem [MEM_WORDS];
	logic pending;
	int waitLeft;
	logic firstSeen;
	logic [31:0] firstAdr;
	logic storeSeen;
	logic [31:0] storeAdr;
	logic [31:0] storeDat;
	logic [3:0] storeSel;

	cpuTop u_cpuTop (
		.CLK(CLK),
		.nRST(nRST),
		.en_i(en),
		.wbDat_i(wbDatIn),
		.wbAck_i(wbAck),
		.wbAdr_o(wbAdr),
		.wbDat_o(wbDatOut),
		.wbSel_o(wbSel),
		.wbWe_o(wbWe),
		.wbStb_o(wbStb),
		.wbCyc_o(wbCyc)
	);

	always #2 CLK = ~CLK;

	// RV32I encoders.
	function automatic logic [31:0] iOp(int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
	endfunction

	function automatic logic [31:0] rOp(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] lw(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'h03};
	endfunction

	function automatic logic [31:0] sw(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] br(int f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] uOp(logic [6:0] opc, int rd, logic [31:0] upper);
		return {upper[31:12], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] jal(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic logic [31:0] jalr(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h67};
	endfunction

	function automatic int wordIndex(logic [31:0] adr);
		logic [31:0] off;
		off = adr - RESET_PC;
		return int'(off[8:2]);
	endfunction

	task automatic addRow(string n, int off, logic [31:0] dat, logic [31:0] pre,
		logic [31:0] i0, logic [31:0] i1 = NOP, logic [31:0] i2 = NOP,
		logic [31:0] i3 = NOP, logic [31:0] i4 = NOP, logic [31:0] i5 = NOP,
		logic [31:0] i6 = NOP, logic [31:0] i7 = NOP);
		names[rowCount] = n;
		progs[rowCount] = '{i0, i1, i2, i3, i4, i5, i6, i7};
		preload[rowCount] = pre;
		expAdr[rowCount] = DATA_BASE + 32'(off);
		expDat[rowCount] = dat;
		rowCount++;
	endtask

	// x1 = a, x2 = b, then op into x3 and store it.
	task automatic aluRow(string n, int a, int b, logic [31:0] op, logic [31:0] dat);
		addRow(n, 'h100, dat, 32'h0, iOp(0, 1, 0, a), iOp(0, 2, 0, b), op, sw(3, 0, 'h100));
	endtask

	// x3 keeps 1 when taken, else becomes 2.
	task automatic branchRow(string n, int f3, int a, int b, logic taken);
		addRow(n, 'h100, taken ? 32'd1 : 32'd2, 32'h0, iOp(0, 1, 0, a), iOp(0, 2, 0, b),
			iOp(0, 3, 0, 1), br(f3, 1, 2, 8), iOp(0, 3, 0, 2), sw(3, 0, 'h100));
	endtask

	task automatic buildTable();
		aluRow("addi", 7, 0, iOp(0, 3, 1, -12), 32'hffff_fffb);
		aluRow("xori", 'h5a5, 0, iOp(4, 3, 1, -1), 32'hffff_fa5a);
		aluRow("sltiu", 1, 0, iOp(3, 3, 1, -1), 32'h1);
		aluRow("srai", -8, 0, iOp(5, 3, 1, 'h401), 32'hffff_fffc);
		aluRow("add", 100, -30, rOp(0, 0, 3, 1, 2), 32'h46);
		aluRow("sub", -30, 100, rOp(32, 0, 3, 1, 2), 32'hffff_ff7e);
		aluRow("xor", 'h5a5, 'h3c3, rOp(0, 4, 3, 1, 2), 32'h666);
		aluRow("or", 'h5a5, 'h3c3, rOp(0, 6, 3, 1, 2), 32'h7e7);
		aluRow("and", 'h5a5, 'h3c3, rOp(0, 7, 3, 1, 2), 32'h181);
		aluRow("sll", -8, 36, rOp(0, 1, 3, 1, 2), 32'hffff_ff80); // shamt is 4.
		aluRow("srl", -8, 36, rOp(0, 5, 3, 1, 2), 32'h0fff_ffff);
		aluRow("sra", -8, 36, rOp(32, 5, 3, 1, 2), 32'hffff_ffff);
		aluRow("slt", -1, 1, rOp(0, 2, 3, 1, 2), 32'h1);
		aluRow("sltu", -1, 1, rOp(0, 3, 3, 2, 1), 32'h1);
		addRow("lui", 'h100, 32'h1234_5000, 32'h0, uOp(7'h37, 1, 32'h1234_5000),
			sw(1, 0, 'h100));
		addRow("auipc", 'h100, RESET_PC + 32'h1004, 32'h0, NOP, uOp(7'h17, 1, 32'h1000),
			sw(1, 0, 'h100));
		branchRow("beq taken", 0, 5, 5, 1'b1);
		branchRow("beq not taken", 0, 5, 6, 1'b0);
		branchRow("bne taken", 1, 5, 6, 1'b1);
		branchRow("bne not taken", 1, 5, 5, 1'b0);
		branchRow("blt taken", 4, -1, 1, 1'b1);
		branchRow("blt not taken", 4, 1, -1, 1'b0);
		branchRow("bge taken", 5, 1, -1, 1'b1);
		branchRow("bge not taken", 5, -1, 1, 1'b0);
		branchRow("bltu taken", 6, 1, -1, 1'b1);
		branchRow("bltu not taken", 6, -1, 1, 1'b0);
		branchRow("bgeu taken", 7, -1, 1, 1'b1);
		branchRow("bgeu not taken", 7, 1, -1, 1'b0);
		addRow("jal", 'h100, RESET_PC + 32'd4, 32'h0, jal(1, 8), iOp(0, 1, 0, 7),
			sw(1, 0, 'h100));
		// target 13 lands on word 3 once bit 0 is cleared.
		addRow("jalr", 'h100, RESET_PC + 32'd8, 32'h0, uOp(7'h37, 5, RESET_PC),
			jalr(1, 5, 13), iOp(0, 1, 0, 7), sw(1, 0, 'h100));
		addRow("x0", 'h100, 32'h0, 32'h0, iOp(0, 0, 0, 9), jal(0, 8), iOp(0, 0, 0, 1),
			sw(0, 0, 'h100));
		addRow("lw", 'h104, 32'h8000_0000, 32'h7fff_ffff, iOp(0, 2, 0, 'h100), lw(1, 2, 0),
			iOp(0, 1, 1, 1), sw(1, 2, 4));
	endtask

	task automatic stopOnError();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error %s: expected %h, actual %h", what, expected, actual);
			stopOnError();
		end
	endtask

	// wishbone memory with 0 to 3 wait states.
	always @(negedge CLK) begin
		if (!nRST) begin
			for (int k = 0; k < MEM_WORDS; k++) begin
				mem[k] = RESET_PC + 32'(4 * k);
			end
			for (int k = 0; k < PLEN; k++) begin
				mem[k] = progs[curRow][k];
			end
			mem[64] = preload[curRow]; // byte offset 0x100.
			pending = 1'b0;
			firstSeen = 1'b0;
			storeSeen = 1'b0;
			wbAck <= 1'b0;
		end else begin
			wbAck <= 1'b0;
			if (wbStb && !wbAck) begin
				if (!firstSeen) begin
					firstSeen = 1'b1;
					firstAdr = wbAdr;
				end
				if (!pending) begin
					pending = 1'b1;
					waitLeft = int'($urandom_range(3, 0));
				end
				if (waitLeft == 0) begin
					pending = 1'b0;
					wbAck <= 1'b1;
					if (wbWe) begin
						mem[wordIndex(wbAdr)] = wbDatOut;
						if (!storeSeen) begin
							storeSeen = 1'b1;
							storeAdr = wbAdr;
							storeDat = wbDatOut;
							storeSel = wbSel;
						end
					end else begin
						wbDatIn <= mem[wordIndex(wbAdr)];
					end
				end else begin
					waitLeft--;
				end
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Error: no store was seen on the bus within %0d cycles", TIMEOUT);
			stopOnError();
		end
	end

	initial begin
		void'($urandom(56531));
		CLK = 1'b0;
		nRST = 1'b0;
		en = 1'b1;
		wbAck = 1'b0;
		wbDatIn = '0;
		curRow = 0;
		buildTable();
		for (int r = 0; r < NROWS; r++) begin
			@(negedge CLK);
			curRow <= r;
			nRST <= 1'b0;
			repeat (2) @(negedge CLK);
			nRST <= 1'b1;
			@(posedge CLK);
			while (!storeSeen) begin
				@(posedge CLK);
			end
			checkValue({names[r], " first fetch address"}, RESET_PC, firstAdr);
			checkValue({names[r], " store address"}, expAdr[r], storeAdr);
			checkValue({names[r], " store data"}, expDat[r], storeDat);
			checkValue({names[r], " byte select"}, 32'hf, {28'h0, storeSel});
		end
		$display("PASS: all tests");
		$finish;
	end
endmodule

// ==== test/cpuTop_sva.sv ====
`timescale 1ns/100ps

module wbProtocolChecks import cpuPkg::*; (
	input logic CLK,
	input logic nRST,
	input logic wbAck_i,
	input logic wbStb_o,
	input logic wbCyc_o,
	input logic wbWe_o,
	input logic [XLEN-1:0] wbAdr_o
);
	stbWithCyc: assert property (@(posedge CLK) disable iff (!nRST) wbStb_o |-> wbCyc_o)
		else $error("STB high without CYC");

	// request held until the slave answers.
	holdUntilAck: assert property (@(posedge CLK) disable iff (!nRST)
		(wbStb_o && !wbAck_i) |=> (wbStb_o && $stable(wbAdr_o) && $stable(wbWe_o)))
		else $error("STB, ADR or WE changed before ACK");

	idleInReset: assert property (@(posedge CLK) !nRST |-> !wbStb_o)
		else $error("STB high while in reset");
endmodule

bind wishboneManager wbProtocolChecks u_wbProtocolChecks (
	.CLK(CLK),
	.nRST(nRST),
	.wbAck_i(wbAck_i),
	.wbStb_o(wbStb_o),
	.wbCyc_o(wbCyc_o),
	.wbWe_o(wbWe_o),
	.wbAdr_o(wbAdr_o)
);
